// File: common/huff_tree_pkg.sv
`default_nettype none

package huff_tree_pkg;

    // node table capacity
    localparam int NODE_COUNT = 64;
    localparam int NODE_IDX_W = 6;

    // symbol width, one byte per leaf
    localparam int SYM_W = 8;

    // walker stack, one entry per ancestor on the current path
    localparam int STACK_DEPTH = 16;
    localparam int STACK_IDX_W = 4;
    // pointer needs one extra bit to tell empty from full
    localparam int STACK_PTR_W = 5;

    typedef logic [SYM_W-1:0] sym_t;
    typedef logic [NODE_IDX_W-1:0] node_idx_t;

    // one tree node, 21 bits
    // child indices are ignored for leaves
    typedef struct packed {
        logic      is_leaf;
        sym_t      symbol;
        node_idx_t left_idx;
        node_idx_t right_idx;
    } tree_node_t;

    // value of an entry after reset: leaf carrying symbol 0
    localparam tree_node_t LEAF_RESET = '{
        is_leaf:   1'b1,
        symbol:    '0,
        left_idx:  '0,
        right_idx: '0
    };

endpackage

`default_nettype wire

// File: common/header_stream_pkg.sv
`default_nettype none

package header_stream_pkg;

    // width of the num_lefts field in a left leaf
    localparam int NUM_LEFTS_W = 8;

    // one serial field: control bit plus 8 data bits
    localparam int HDR_FIELD_W = 9;
    localparam int HDR_CNT_W = 4;

    // packer side
    localparam int BYTE_W = 8;
    localparam int BYTE_IDX_W = 3;
    localparam int BIT_COUNT_W = 16;

    // walker event kinds
    typedef enum logic [1:0] {
        EV_NONE,
        EV_LEAF,
        EV_BACK
    } hdr_ev_e;

    // one event from walker to synthesis, 19 bits
    typedef struct packed {
        hdr_ev_e                kind;
        huff_tree_pkg::sym_t    symbol;
        logic                   is_left;
        logic [NUM_LEFTS_W-1:0] num_lefts;
    } hdr_event_t;

    // packed output byte with its strobe
    typedef struct packed {
        logic              valid;
        logic [BYTE_W-1:0] data;
    } hdr_byte_t;

endpackage

`default_nettype wire

// File: verilog/node_table.sv
`default_nettype none

// node storage written by the host, read by the walker
module node_table (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      node_wr,
    input  huff_tree_pkg::node_idx_t  node_addr,
    input  huff_tree_pkg::tree_node_t node_wdata,
    input  huff_tree_pkg::node_idx_t  rd_addr,
    output huff_tree_pkg::tree_node_t rd_data
);
    import huff_tree_pkg::*;

    tree_node_t nodes [NODE_COUNT];

    // table and read register share one process
    // every entry comes out of reset as an empty leaf
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NODE_COUNT; i++) begin
                nodes[i] <= LEAF_RESET;
            end
            rd_data <= LEAF_RESET;
        end else begin
            // host write port
            if (node_wr) begin
                nodes[node_addr] <= node_wdata;
            end
            // walker read, one cycle latency
            // a write to the same entry shows up on the next read
            rd_data <= nodes[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: header_synth/tree_walker.sv
`default_nettype none

// depth-first pre-order walk over the node table
// one event per leaf, one EV_BACK per edge climbed
module tree_walker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    output huff_tree_pkg::node_idx_t      rd_addr,
    input  huff_tree_pkg::tree_node_t     rd_data,
    input  logic                          seg_done,
    output header_stream_pkg::hdr_event_t ev,
    output logic                          walk_end,
    output logic                          busy
);
    import huff_tree_pkg::*;
    import header_stream_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EMIT,
        WAIT_SEG,
        CLIMB,
        DONE
    } walk_state_e;

    walk_state_e state;

    node_idx_t              cur_idx;
    logic [STACK_PTR_W-1:0] sp;
    logic [STACK_IDX_W-1:0] top;
    logic [NUM_LEFTS_W-1:0] lefts;
    // current segment is a backtrack zero
    logic                   seg_back;

    // per ancestor: right child still to visit, and the side taken
    node_idx_t stk_right [STACK_DEPTH];
    logic      stk_dir [STACK_DEPTH];

    logic      top_dir;
    node_idx_t top_right;
    logic      push;
    logic      turn_right;

    assign top = STACK_IDX_W'(sp - 1'b1);
    assign top_dir = stk_dir[top];
    assign top_right = stk_right[top];

    // internal node reached, go down the left edge
    assign push = (state == EMIT) && !seg_back && !rd_data.is_leaf;
    // zero for a left edge sent, move over to the right child
    assign turn_right = (state == WAIT_SEG) && seg_done && seg_back && !top_dir;

    // read address follows the node under visit
    assign rd_addr = cur_idx;
    assign busy = (state != IDLE);
    assign walk_end = (state == DONE);

    // events only from EMIT
    // node data is valid there, one cycle after FETCH
    always_comb begin
        ev = '0;
        ev.kind = EV_NONE;
        if (state == EMIT) begin
            if (seg_back) begin
                ev.kind = EV_BACK;
            end else if (rd_data.is_leaf) begin
                ev.kind = EV_LEAF;
                ev.symbol = rd_data.symbol;
                // left child of its parent, never the root
                ev.is_left = (sp != '0) && !top_dir;
                ev.num_lefts = lefts;
            end
        end
    end

    // stack contents
    always_ff @(posedge clk) begin
        if (push) begin
            stk_right[sp[STACK_IDX_W-1:0]] <= rd_data.right_idx;
            stk_dir[sp[STACK_IDX_W-1:0]] <= 1'b0;
        end else if (turn_right) begin
            stk_dir[top] <= 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cur_idx <= '0;
            sp <= '0;
            lefts <= '0;
            seg_back <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // root sits at index 0
                    if (start) begin
                        cur_idx <= '0;
                        sp <= '0;
                        lefts <= '0;
                        seg_back <= 1'b0;
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    state <= EMIT;
                end
                EMIT: begin
                    if (seg_back || rd_data.is_leaf) begin
                        state <= WAIT_SEG;
                    end else begin
                        // descend left, one more left edge on the path
                        cur_idx <= rd_data.left_idx;
                        sp <= sp + 1'b1;
                        lefts <= lefts + 1'b1;
                        state <= FETCH;
                    end
                end
                WAIT_SEG: begin
                    if (seg_done) begin
                        if (!seg_back) begin
                            // leaf done, lone root leaf ends the walk
                            state <= (sp == '0) ? DONE : CLIMB;
                        end else if (!top_dir) begin
                            // back at parent from the left, left edge dropped
                            cur_idx <= top_right;
                            lefts <= lefts - 1'b1;
                            seg_back <= 1'b0;
                            state <= FETCH;
                        end else begin
                            // both sides done, parent subtree complete
                            sp <= sp - 1'b1;
                            state <= (sp == STACK_PTR_W'(1)) ? DONE : CLIMB;
                        end
                    end
                end
                CLIMB: begin
                    // zero for the edge up to the stack top
                    seg_back <= 1'b1;
                    state <= EMIT;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: header_synth/header_synthesis.sv
`default_nettype none

// turns walker events into serial header bits
// leaf:      1, symbol msb first
// left leaf: then 1, num_lefts msb first
// backtrack: a single 0
module header_synthesis (
    input  logic                          clk,
    input  logic                          rst,
    input  header_stream_pkg::hdr_event_t ev,
    output logic                          bit_valid,
    output logic                          bit_value,
    output logic                          seg_done
);
    import header_stream_pkg::*;

    typedef enum logic [1:0] {
        SH_IDLE,
        SH_HEADER,
        SH_LEFTS,
        SH_BACK
    } synth_state_e;

    synth_state_e state;

    // bit currently on the output sits in the msb
    logic [HDR_FIELD_W-1:0] shreg;
    logic [HDR_CNT_W-1:0]   cnt;

    // left leaf info kept for the second field
    logic                   left_q;
    logic [NUM_LEFTS_W-1:0] lefts_q;

    logic field_last;

    // ninth bit of a field on the output
    assign field_last = (cnt == HDR_CNT_W'(HDR_FIELD_W - 1));

    // one bit per cycle whenever a segment is running
    assign bit_valid = (state != SH_IDLE);
    assign bit_value = bit_valid & shreg[HDR_FIELD_W-1];

    // high with the last bit of the segment
    always_comb begin
        seg_done = 1'b0;
        case (state)
            SH_HEADER: seg_done = field_last && !left_q;
            SH_LEFTS:  seg_done = field_last;
            SH_BACK:   seg_done = 1'b1;
            default:   seg_done = 1'b0;
        endcase
    end

    // segment control
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= SH_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                SH_IDLE: begin
                    cnt <= '0;
                    if (ev.kind == EV_LEAF) begin
                        state <= SH_HEADER;
                    end else if (ev.kind == EV_BACK) begin
                        state <= SH_BACK;
                    end
                end
                SH_HEADER: begin
                    if (field_last) begin
                        cnt <= '0;
                        // left leaves carry a second field
                        state <= left_q ? SH_LEFTS : SH_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SH_LEFTS: begin
                    if (field_last) begin
                        cnt <= '0;
                        state <= SH_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SH_BACK: begin
                    // single zero, done in one cycle
                    state <= SH_IDLE;
                end
                default: begin
                    state <= SH_IDLE;
                end
            endcase
        end
    end

    // shift register and latched event fields
    always_ff @(posedge clk) begin
        if (state == SH_IDLE) begin
            if (ev.kind == EV_LEAF) begin
                // control 1 ahead of the symbol
                shreg <= {1'b1, ev.symbol};
                left_q <= ev.is_left;
                lefts_q <= ev.num_lefts;
            end else if (ev.kind == EV_BACK) begin
                shreg <= '0;
            end
        end else if ((state == SH_HEADER) && field_last) begin
            // leading 1 then the left count
            shreg <= {1'b1, lefts_q};
        end else begin
            shreg <= {shreg[HDR_FIELD_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: verilog/bit_packer.sv
`default_nettype none

// gathers header bits into bytes, msb first
module bit_packer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic                                   bit_valid,
    input  logic                                   bit_value,
    input  logic                                   walk_end,
    output header_stream_pkg::hdr_byte_t           out,
    output logic                                   header_done,
    output logic [header_stream_pkg::BIT_COUNT_W-1:0] bit_count
);
    import header_stream_pkg::*;

    // header in progress, a start is ignored while set
    logic                  active;
    logic [BYTE_W-1:0]     byte_sr;
    // bits already in byte_sr
    logic [BYTE_IDX_W-1:0] nbits;
    logic                  out_valid;
    logic [BYTE_W-1:0]     out_data;

    logic [BYTE_W-1:0] byte_next;
    logic [BYTE_W-1:0] flush_data;
    logic              byte_full;

    assign byte_next = {byte_sr[BYTE_W-2:0], bit_value};
    assign byte_full = bit_valid && (nbits == BYTE_IDX_W'(BYTE_W - 1));
    // partial byte moved up to the msb, zeros below
    assign flush_data = byte_sr << (BYTE_W - nbits);

    assign out = '{valid: out_valid, data: out_data};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            nbits <= '0;
            bit_count <= '0;
            out_valid <= 1'b0;
            header_done <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            header_done <= 1'b0;
            if (start && !active) begin
                active <= 1'b1;
                nbits <= '0;
                bit_count <= '0;
            end else begin
                if (bit_valid) begin
                    // wraps to 0 after the eighth bit
                    nbits <= nbits + 1'b1;
                    bit_count <= bit_count + 1'b1;
                    out_valid <= byte_full;
                end
                // synthesis is idle here, no bit arrives with walk_end
                if (walk_end) begin
                    active <= 1'b0;
                    nbits <= '0;
                    out_valid <= (nbits != '0);
                    header_done <= 1'b1;
                end
            end
        end
    end

    // byte data path
    always_ff @(posedge clk) begin
        if (bit_valid) begin
            byte_sr <= byte_next;
        end
        if (byte_full) begin
            out_data <= byte_next;
        end else if (walk_end) begin
            out_data <= flush_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/huff_header_top.sv
`default_nettype none

// huffman header stage
// node table -> walker -> synthesis -> packer
module huff_header_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   node_wr,
    input  huff_tree_pkg::node_idx_t               node_addr,
    input  huff_tree_pkg::tree_node_t              node_wdata,
    input  logic                                   start,
    output logic                                   busy,
    output header_stream_pkg::hdr_byte_t           out,
    output logic                                   header_done,
    output logic [header_stream_pkg::BIT_COUNT_W-1:0] bit_count
);
    import huff_tree_pkg::*;
    import header_stream_pkg::*;

    // walker <-> table
    node_idx_t  rd_addr;
    tree_node_t rd_data;

    // walker <-> synthesis
    hdr_event_t ev;
    logic       seg_done;

    // synthesis -> packer
    logic bit_valid;
    logic bit_value;

    // walker -> packer
    logic walk_end;

    node_table u_node_table (
        .clk        (clk),
        .rst        (rst),
        .node_wr    (node_wr),
        .node_addr  (node_addr),
        .node_wdata (node_wdata),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    tree_walker u_tree_walker (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .seg_done (seg_done),
        .ev       (ev),
        .walk_end (walk_end),
        .busy     (busy)
    );

    header_synthesis u_header_synthesis (
        .clk       (clk),
        .rst       (rst),
        .ev        (ev),
        .bit_valid (bit_valid),
        .bit_value (bit_value),
        .seg_done  (seg_done)
    );

    bit_packer u_bit_packer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .bit_valid   (bit_valid),
        .bit_value   (bit_value),
        .walk_end    (walk_end),
        .out         (out),
        .header_done (header_done),
        .bit_count   (bit_count)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

// clock and reset for the testbench
module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/huff_header_tb.sv
`default_nettype none

module huff_header_tb;
    import huff_tree_pkg::*;
    import header_stream_pkg::*;

    logic                   clk;
    logic                   rst;
    logic                   node_wr;
    node_idx_t              node_addr;
    tree_node_t             node_wdata;
    logic                   start;
    logic                   busy;
    hdr_byte_t              out;
    logic                   header_done;
    logic [BIT_COUNT_W-1:0] bit_count;

    // tree under test as mirrored into the node table
    logic      t_leaf [NODE_COUNT];
    sym_t      t_sym [NODE_COUNT];
    node_idx_t t_left [NODE_COUNT];
    node_idx_t t_right [NODE_COUNT];
    int        t_depth [NODE_COUNT];
    int        n_nodes;

    // expected header from the reference model
    bit         exp_bits[$];
    logic [7:0] exp_bytes[$];
    int         exp_count;
    logic [7:0] want_byte;

    int seed;
    int errors;
    int tests;
    int failed;
    int budget;
    int cycles;
    bit done_seen;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(16)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    huff_header_top UUT (
        .clk         (clk),
        .rst         (rst),
        .node_wr     (node_wr),
        .node_addr   (node_addr),
        .node_wdata  (node_wdata),
        .start       (start),
        .busy        (busy),
        .out         (out),
        .header_done (header_done),
        .bit_count   (bit_count)
    );

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // append a fresh leaf and return its index
    function automatic int new_leaf(input sym_t sym, input int depth);
        t_leaf[n_nodes] = 1'b1;
        t_sym[n_nodes] = sym;
        t_left[n_nodes] = '0;
        t_right[n_nodes] = '0;
        t_depth[n_nodes] = depth;
        n_nodes++;
        return n_nodes - 1;
    endfunction

    // turn a leaf into an internal node with two new leaves
    function automatic void split(input int idx, input sym_t sym_l, input sym_t sym_r);
        int l;
        int r;
        l = new_leaf(sym_l, t_depth[idx] + 1);
        r = new_leaf(sym_r, t_depth[idx] + 1);
        t_leaf[idx] = 1'b0;
        t_left[idx] = node_idx_t'(l);
        t_right[idx] = node_idx_t'(r);
    endfunction

    // grow by splitting random leaves above depth 15
    task automatic make_random_tree(input int leaves);
        int count;
        int pick;
        n_nodes = 0;
        pick = new_leaf(sym_t'(next_rand()), 0);
        count = 1;
        while (count < leaves) begin
            pick = int'(next_rand() % 32'(n_nodes));
            if (t_leaf[pick] && t_depth[pick] < 15) begin
                split(pick, sym_t'(next_rand()), sym_t'(next_rand()));
                count++;
            end
        end
    endtask

    // control 1 then eight bits msb first
    task automatic push_field(input logic [7:0] val);
        exp_bits.push_back(1'b1);
        for (int i = 7; i >= 0; i--) begin
            exp_bits.push_back(val[i]);
        end
    endtask

    // header rule applied straight to the tree
    task automatic emit_subtree(input int idx, input bit is_left, input int nlefts);
        if (t_leaf[idx]) begin
            push_field(t_sym[idx]);
            if (is_left) begin
                push_field(8'(nlefts));
            end
        end else begin
            emit_subtree(int'(t_left[idx]), 1'b1, nlefts + 1);
            exp_bits.push_back(1'b0);
            emit_subtree(int'(t_right[idx]), 1'b0, nlefts);
            exp_bits.push_back(1'b0);
        end
    endtask

    // pack bits into bytes with a zero padded tail
    task automatic build_expected();
        logic [7:0] b;
        exp_bits.delete();
        exp_bytes.delete();
        emit_subtree(0, 1'b0, 0);
        exp_count = exp_bits.size();
        for (int i = 0; i < exp_count; i += 8) begin
            b = '0;
            for (int j = 0; j < 8; j++) begin
                if (i + j < exp_count) begin
                    b[7 - j] = exp_bits[i + j];
                end
            end
            exp_bytes.push_back(b);
        end
    endtask

    task automatic load_tree();
        for (int i = 0; i < n_nodes; i++) begin
            @(negedge clk);
            node_wr = 1'b1;
            node_addr = node_idx_t'(i);
            node_wdata = '{is_leaf: t_leaf[i], symbol: t_sym[i],
                           left_idx: t_left[i], right_idx: t_right[i]};
        end
        @(negedge clk);
        node_wr = 1'b0;
    endtask

    task automatic run_test(input string name, input bit restart);
        int errs_before;
        errs_before = errors;
        build_expected();
        budget += 20 * exp_count + 100;
        load_tree();
        done_seen = 1'b0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (restart) begin
            // second start in the middle of the walk
            repeat (8) @(negedge clk);
            assert (busy) else begin
                $display("DUT was idle when the second start was given at %0t", $time);
                errors++;
            end
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        while (!done_seen) @(negedge clk);
        assert (!busy) else begin
            $display("DUT still busy after header_done at %0t", $time);
            errors++;
        end
        tests++;
        if (errors > errs_before) begin
            failed++;
        end
        $display("test %0d %s: %0d bits, %0d bytes, %0d errors", tests, name,
                 exp_count, (exp_count + 7) / 8, errors - errs_before);
    endtask

    // output checks on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (out.valid) begin
                assert (exp_bytes.size() > 0) else begin
                    $display("byte %02h arrived with nothing expected at %0t", out.data, $time);
                    errors++;
                end
                if (exp_bytes.size() > 0) begin
                    want_byte = exp_bytes.pop_front();
                    assert (out.data == want_byte) else begin
                        $display("Mismatch at %0t: out.data = %02h, expected %02h",
                                 $time, out.data, want_byte);
                        errors++;
                    end
                end
            end
            if (header_done) begin
                assert (bit_count == 16'(exp_count)) else begin
                    $display("Mismatch at %0t: bit_count = %0d, expected %0d",
                             $time, bit_count, exp_count);
                    errors++;
                end
                assert (exp_bytes.size() == 0) else begin
                    $display("header ended with %0d bytes missing", exp_bytes.size());
                    errors++;
                end
                // flushed tail byte shares the cycle with header_done
                assert ((exp_count % 8 == 0) || out.valid) else begin
                    $display("partial last byte did not come with header_done at %0t", $time);
                    errors++;
                end
                done_seen = 1'b1;
            end
        end
    end

    // watchdog budget grows as each test is set up
    always @(posedge clk) begin
        cycles++;
        if (cycles > budget) begin
            $display("watchdog: run did not finish within %0d cycles", budget);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int root;
        seed = 32'h6992_e4b9;
        node_wr = 1'b0;
        node_addr = '0;
        node_wdata = '0;
        start = 1'b0;
        errors = 0;
        tests = 0;
        failed = 0;
        cycles = 0;
        budget = 16 + 100;
        exp_count = 0;
        done_seen = 1'b0;

        @(negedge clk);
        while (rst) @(negedge clk);
        assert (!busy && !out.valid && !header_done) else begin
            $display("outputs not idle after reset");
            errors++;
        end

        // root alone gives 9 bits in two bytes
        n_nodes = 0;
        root = new_leaf(8'ha5, 0);
        run_test("single leaf", 1'b0);

        n_nodes = 0;
        root = new_leaf(8'h00, 0);
        split(root, 8'h3c, 8'hc3);
        run_test("two leaves", 1'b0);

        // num_lefts climbs to 15 at the bottom
        n_nodes = 0;
        root = new_leaf(8'h00, 0);
        for (int d = 0; d < 15; d++) begin
            split(root, 8'(d * 17 + 1), 8'(8'hf0 - d));
            root = int'(t_left[root]);
        end
        run_test("left spine", 1'b0);

        for (int k = 0; k < 8; k++) begin
            make_random_tree((k == 0) ? 31 : 1 + int'(next_rand() % 32'd31));
            run_test("random tree", 1'b0);
        end

        make_random_tree(12);
        run_test("start while busy", 1'b1);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/huff_tree_pkg.sv
common/header_stream_pkg.sv
verilog/node_table.sv
header_synth/tree_walker.sv
header_synth/header_synthesis.sv
verilog/bit_packer.sv
verilog/huff_header_top.sv
tests/tb_clock.sv
tests/huff_header_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module huff_header_tb -f verilog.f \
    && ./obj_dir/Vhuff_header_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
